/* branch_hazard_unit.sv */
`include "id_consts.svh"

module branch_hazard_unit import isa_pkg::*, pipe_pkg::*; (
    input  if_id_t           if_id_i,
    input  decode_ctrl_t     ctrl_i,
    input  logic [`XLEN-1:0] src1_i,
    input  logic [`XLEN-1:0] src2_i,
    input  logic             hazard_i [2],
    output redirect_t        redirect_o,
    output logic             stall_o
);

    inst_fields_t     f;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] abs_target;
    logic [`XLEN-1:0] br_target;
    logic             cond;

    assign f       = inst_fields_t'(if_id_i.inst);
    assign pc_next = if_id_i.pc + `PC_STEP;

    // region of the delay slot, index is word aligned
    assign abs_target = {pc_next[`XLEN-1:`INDEX_W+2], f.b.index, 2'b00};
    assign br_target  = pc_next
                      + {{(`XLEN-`IMM_W-2){f.b.f.lo.imm[`IMM_W-1]}}, f.b.f.lo.imm, 2'b00};

    always_comb begin
        case (ctrl_i.aluop)
            ALU_BEQ:                cond = (src1_i == src2_i);
            ALU_BNE:                cond = (src1_i != src2_i);
            ALU_BGTZ:               cond = ($signed(src1_i) > 0);
            ALU_BLEZ:               cond = ($signed(src1_i) <= 0);
            ALU_BGEZ, ALU_BGEZAL:   cond = ~src1_i[`XLEN-1];
            ALU_BLTZ, ALU_BLTZAL:   cond = src1_i[`XLEN-1];
            default:                cond = 1'b0;
        endcase
    end

    always_comb begin
        stall_o = if_id_i.valid && (hazard_i[0] || hazard_i[1]);

        // operands are stale while stalled, so hold off the redirect
        redirect_o.taken = if_id_i.valid && !stall_o
                         && (ctrl_i.is_jump_abs || ctrl_i.is_jump_reg
                             || (ctrl_i.is_branch && cond));

        if (!redirect_o.taken)
            redirect_o.target = '0;
        else if (ctrl_i.is_jump_reg)
            redirect_o.target = src1_i;
        else if (ctrl_i.is_jump_abs)
            redirect_o.target = abs_target;
        else
            redirect_o.target = br_target;
    end

endmodule

/* flist.f */
+incdir+.
isa_pkg.sv
pipe_pkg.sv
inst_decoder.sv
operand_fwd.sv
branch_hazard_unit.sv
id_ex_reg.sv
id_stage_top.sv
tb_id_stage.sv

/* id_consts.svh */
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// datapath and register file geometry
`define XLEN        32
`define REG_AW      5

// jal and the linking branches write here
`define LINK_REG    5'd31

// sequential fetch step
`define PC_STEP     32'd4

// return address skips the delay slot
`define RET_OFFSET  32'd8

// instruction field widths
`define IMM_W       16
`define INDEX_W     26

`endif

/* id_ex_reg.sv */
`include "id_consts.svh"

module id_ex_reg import isa_pkg::*, pipe_pkg::*; (
    input  logic             cpu_clk_50M,
    input  logic             arst_n_i,
    input  if_id_t           if_id_i,
    input  decode_ctrl_t     ctrl_i,
    input  logic [`XLEN-1:0] src1_i,
    input  logic [`XLEN-1:0] src2_i,
    input  logic             stall_i,
    output id_ex_t           id_ex_o
);

    inst_fields_t f;
    id_ex_t       nxt;

    assign f = inst_fields_t'(if_id_i.inst);

    always_comb begin
        // bubble by default
        nxt = '0;
        if (if_id_i.valid && !stall_i) begin
            nxt.valid   = 1'b1;
            nxt.alutype = ctrl_i.alutype;
            nxt.aluop   = ctrl_i.aluop;
            nxt.wa      = ctrl_i.wa;
            nxt.wreg    = ctrl_i.wreg;
            nxt.mreg    = ctrl_i.mreg;

            // shift amount replaces port 0 for fixed shifts
            if (ctrl_i.shift_imm)
                nxt.src1 = {{(`XLEN-`REG_AW){1'b0}}, f.b.f.lo.r.sa};
            else
                nxt.src1 = src1_i;

            if (ctrl_i.immsel)
                nxt.src2 = ctrl_i.imm_ext;
            else
                nxt.src2 = src2_i;

            // store data still comes from the rt port
            if (ctrl_i.smem)
                nxt.din = src2_i;

            nxt.retaddr = if_id_i.pc + `RET_OFFSET;
        end
    end

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= nxt;
        end
    end

    // fetch holds the stalled instruction
    assert property (@(posedge cpu_clk_50M) disable iff (!arst_n_i)
                     stall_i |=> $stable(if_id_i))
        else $error("id_ex_reg: fetch changed if_id_i during a stall");

    // load-use stall ends once the load leaves memory
    assert property (@(posedge cpu_clk_50M) disable iff (!arst_n_i)
                     (stall_i && $past(stall_i)) |=> !stall_i)
        else $error("id_ex_reg: stall held for more than two cycles");

endmodule

/* id_stage_top.sv */
`include "id_consts.svh"

module id_stage_top import isa_pkg::*, pipe_pkg::*; (
    input  logic             cpu_clk_50M,
    input  logic             arst_n_i,
    input  if_id_t           if_id_i,
    input  logic [`XLEN-1:0] rd_data_i [2],
    input  bypass_t          exe_byp_i,
    input  bypass_t          mem_byp_i,
    output rf_port_t         rf_port_o [2],
    output redirect_t        redirect_o,
    output logic             stall_o,
    output id_ex_t           id_ex_o
);

    decode_ctrl_t     ctrl;
    logic [`XLEN-1:0] operand [2];
    logic             hazard [2];

    inst_decoder u_inst_decoder (
        .if_id_i (if_id_i),
        .ctrl_o  (ctrl)
    );

    // port 0 is rs, port 1 is rt
    for (genvar k = 0; k < 2; k++) begin : g_port
        operand_fwd #(
            .PORT (bit'(k))
        ) u_operand_fwd (
            .fields_i  (inst_fields_t'(if_id_i.inst)),
            .ctrl_i    (ctrl),
            .rd_data_i (rd_data_i[k]),
            .exe_byp_i (exe_byp_i),
            .mem_byp_i (mem_byp_i),
            .rf_port_o (rf_port_o[k]),
            .operand_o (operand[k]),
            .hazard_o  (hazard[k])
        );
    end

    branch_hazard_unit u_branch_hazard_unit (
        .if_id_i    (if_id_i),
        .ctrl_i     (ctrl),
        .src1_i     (operand[0]),
        .src2_i     (operand[1]),
        .hazard_i   (hazard),
        .redirect_o (redirect_o),
        .stall_o    (stall_o)
    );

    id_ex_reg u_id_ex_reg (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .if_id_i     (if_id_i),
        .ctrl_i      (ctrl),
        .src1_i      (operand[0]),
        .src2_i      (operand[1]),
        .stall_i     (stall_o),
        .id_ex_o     (id_ex_o)
    );

endmodule

/* inst_decoder.sv */
`include "id_consts.svh"

module inst_decoder import isa_pkg::*, pipe_pkg::*; (
    input  if_id_t       if_id_i,
    output decode_ctrl_t ctrl_o
);

    inst_fields_t f;
    alu_op_e      aluop;
    decode_ctrl_t c;
    logic         r_arith;
    logic         r_logic;
    logic         i_arith;
    logic         i_logic;
    logic         sh_sa;
    logic         sh_v;
    logic         ld;
    logic         st;
    logic         jmp_abs;
    logic         jmp_reg;
    logic         br;
    logic         link;
    logic         sext;

    assign f = inst_fields_t'(if_id_i.inst);

    // opcode first, then funct or rt for the two shared opcodes
    always_comb begin
        aluop = ALU_NOP;
        case (f.op)
            OP_SPECIAL: begin
                case (f.b.f.lo.r.funct)
                    FN_ADD:  aluop = ALU_ADD;
                    FN_ADDU: aluop = ALU_ADDU;
                    FN_SUB:  aluop = ALU_SUB;
                    FN_SUBU: aluop = ALU_SUBU;
                    FN_AND:  aluop = ALU_AND;
                    FN_OR:   aluop = ALU_OR;
                    FN_XOR:  aluop = ALU_XOR;
                    FN_NOR:  aluop = ALU_NOR;
                    FN_SLT:  aluop = ALU_SLT;
                    FN_SLTU: aluop = ALU_SLTU;
                    FN_SLL:  aluop = ALU_SLL;
                    FN_SRL:  aluop = ALU_SRL;
                    FN_SRA:  aluop = ALU_SRA;
                    FN_SLLV: aluop = ALU_SLLV;
                    FN_SRLV: aluop = ALU_SRLV;
                    FN_SRAV: aluop = ALU_SRAV;
                    FN_JR:   aluop = ALU_JR;
                    FN_JALR: aluop = ALU_JALR;
                    default: aluop = ALU_NOP;
                endcase
            end
            OP_REGIMM: begin
                case (regimm_e'(f.b.f.rt))
                    RI_BLTZ:   aluop = ALU_BLTZ;
                    RI_BGEZ:   aluop = ALU_BGEZ;
                    RI_BLTZAL: aluop = ALU_BLTZAL;
                    RI_BGEZAL: aluop = ALU_BGEZAL;
                    default:   aluop = ALU_NOP;
                endcase
            end
            OP_J:     aluop = ALU_J;
            OP_JAL:   aluop = ALU_JAL;
            OP_BEQ:   aluop = ALU_BEQ;
            OP_BNE:   aluop = ALU_BNE;
            OP_BLEZ:  aluop = ALU_BLEZ;
            OP_BGTZ:  aluop = ALU_BGTZ;
            OP_ADDI:  aluop = ALU_ADDI;
            OP_ADDIU: aluop = ALU_ADDIU;
            OP_SLTI:  aluop = ALU_SLTI;
            OP_SLTIU: aluop = ALU_SLTIU;
            OP_ANDI:  aluop = ALU_ANDI;
            OP_ORI:   aluop = ALU_ORI;
            OP_XORI:  aluop = ALU_XORI;
            OP_LUI:   aluop = ALU_LUI;
            OP_LB:    aluop = ALU_LB;
            OP_LH:    aluop = ALU_LH;
            OP_LW:    aluop = ALU_LW;
            OP_LBU:   aluop = ALU_LBU;
            OP_LHU:   aluop = ALU_LHU;
            OP_SB:    aluop = ALU_SB;
            OP_SH:    aluop = ALU_SH;
            OP_SW:    aluop = ALU_SW;
            default:  aluop = ALU_NOP;
        endcase
    end

    assign r_arith = aluop inside {ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU};
    assign r_logic = aluop inside {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR};
    assign i_arith = aluop inside {ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU};
    assign i_logic = aluop inside {ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LUI};
    assign sh_sa   = aluop inside {ALU_SLL, ALU_SRL, ALU_SRA};
    assign sh_v    = aluop inside {ALU_SLLV, ALU_SRLV, ALU_SRAV};
    assign ld      = aluop inside {ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU};
    assign st      = aluop inside {ALU_SB, ALU_SH, ALU_SW};
    assign jmp_abs = aluop inside {ALU_J, ALU_JAL};
    assign jmp_reg = aluop inside {ALU_JR, ALU_JALR};
    assign br      = aluop inside {ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
                                   ALU_BLTZ, ALU_BGEZ, ALU_BLTZAL, ALU_BGEZAL};
    assign link    = aluop inside {ALU_JAL, ALU_BLTZAL, ALU_BGEZAL};
    assign sext    = i_arith | ld | st;

    always_comb begin
        c       = '0;
        c.aluop = aluop;
        if (r_arith || i_arith)
            c.alutype = ALUT_ARITH;
        else if (r_logic || i_logic)
            c.alutype = ALUT_LOGIC;
        else if (sh_sa || sh_v)
            c.alutype = ALUT_SHIFT;
        else if (ld || st)
            c.alutype = ALUT_MEM;
        else if (jmp_abs || jmp_reg || br)
            c.alutype = ALUT_JUMP;

        c.wreg = r_arith | r_logic | i_arith | i_logic | sh_sa | sh_v | ld | link
               | (aluop == ALU_JALR);
        c.mreg = ld;
        // link target, then rt for I-type writers, rd otherwise
        if (link)
            c.wa = `LINK_REG;
        else if (i_arith || i_logic || ld)
            c.wa = f.b.f.rt;
        else
            c.wa = f.b.f.lo.r.rd;

        c.rreg1 = r_arith | r_logic | i_arith | (i_logic & (aluop != ALU_LUI))
                | sh_v | ld | st | jmp_reg | br;
        c.rreg2 = r_arith | r_logic | sh_sa | sh_v | st
                | (aluop == ALU_BEQ) | (aluop == ALU_BNE);

        c.shift_imm   = sh_sa;
        c.immsel      = i_arith | i_logic | ld | st;
        c.smem        = st;
        c.is_jump_abs = jmp_abs;
        c.is_jump_reg = jmp_reg;
        c.is_branch   = br;

        if (aluop == ALU_LUI)
            c.imm_ext = {f.b.f.lo.imm, {(`XLEN-`IMM_W){1'b0}}};
        else if (sext)
            c.imm_ext = {{(`XLEN-`IMM_W){f.b.f.lo.imm[`IMM_W-1]}}, f.b.f.lo.imm};
        else
            c.imm_ext = {{(`XLEN-`IMM_W){1'b0}}, f.b.f.lo.imm};
    end

    assign ctrl_o = if_id_i.valid ? c : '0;

endmodule

/* isa_pkg.sv */
`include "id_consts.svh"

package isa_pkg;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LH      = 6'h21,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_LHU     = 6'h25,
        OP_SB      = 6'h28,
        OP_SH      = 6'h29,
        OP_SW      = 6'h2b
    } op_e;

    // function code under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // rt field under OP_REGIMM
    typedef enum logic [4:0] {
        RI_BLTZ   = 5'h00,
        RI_BGEZ   = 5'h01,
        RI_BLTZAL = 5'h10,
        RI_BGEZAL = 5'h11
    } regimm_e;

    typedef struct packed {
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] sa;
        funct_e             funct;
    } rfmt_t;

    // low half is either rd/sa/funct or the immediate
    typedef union packed {
        rfmt_t             r;
        logic [`IMM_W-1:0] imm;
    } low_u;

    typedef struct packed {
        logic [`REG_AW-1:0] rs;
        logic [`REG_AW-1:0] rt;
        low_u               lo;
    } body_t;

    // everything below the opcode doubles as the jump index
    typedef union packed {
        body_t               f;
        logic [`INDEX_W-1:0] index;
    } body_u;

    typedef struct packed {
        op_e   op;
        body_u b;
    } inst_fields_t;

endpackage

/* operand_fwd.sv */
`include "id_consts.svh"

module operand_fwd import isa_pkg::*, pipe_pkg::*; #(
    parameter bit PORT = 1'b0
) (
    input  inst_fields_t     fields_i,
    input  decode_ctrl_t     ctrl_i,
    input  logic [`XLEN-1:0] rd_data_i,
    input  bypass_t          exe_byp_i,
    input  bypass_t          mem_byp_i,
    output rf_port_t         rf_port_o,
    output logic [`XLEN-1:0] operand_o,
    output logic             hazard_o
);

    logic               en;
    logic [`REG_AW-1:0] ra;
    logic               exe_hit;
    logic               mem_hit;

    // port 0 reads rs, port 1 reads rt
    assign en = PORT ? ctrl_i.rreg2 : ctrl_i.rreg1;
    assign ra = PORT ? fields_i.b.f.rt : fields_i.b.f.rs;

    // r0 is matched like any other register
    assign exe_hit = exe_byp_i.wreg && (exe_byp_i.wa == ra);
    assign mem_hit = mem_byp_i.wreg && (mem_byp_i.wa == ra);

    always_comb begin
        rf_port_o.rreg = en;
        rf_port_o.ra   = ra;

        // younger stage wins
        if (!en)
            operand_o = '0;
        else if (exe_hit)
            operand_o = exe_byp_i.wd;
        else if (mem_hit)
            operand_o = mem_byp_i.wd;
        else
            operand_o = rd_data_i;

        // load data not available yet in either stage
        hazard_o = en && ((exe_hit && exe_byp_i.mreg) || (mem_hit && mem_byp_i.mreg));
    end

endmodule

/* pipe_pkg.sv */
`include "id_consts.svh"

package pipe_pkg;

    typedef enum logic [2:0] {
        ALUT_NOP   = 3'd0,
        ALUT_ARITH = 3'd1,
        ALUT_LOGIC = 3'd2,
        ALUT_SHIFT = 3'd3,
        ALUT_MEM   = 3'd4,
        ALUT_JUMP  = 3'd5
    } alu_type_e;

    // one code per kept instruction
    typedef enum logic [5:0] {
        ALU_NOP, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
        ALU_ADDI, ALU_ADDIU, ALU_SLTI, ALU_SLTIU,
        ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LUI,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV,
        ALU_LB, ALU_LH, ALU_LW, ALU_LBU, ALU_LHU,
        ALU_SB, ALU_SH, ALU_SW,
        ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ,
        ALU_BLTZ, ALU_BGEZ, ALU_BLTZAL, ALU_BGEZAL
    } alu_op_e;

    typedef struct packed {
        alu_type_e          alutype;
        alu_op_e            aluop;
        logic [`REG_AW-1:0] wa;
        logic               wreg;
        logic               mreg;
        logic               rreg1;
        logic               rreg2;
        logic               shift_imm;
        logic               immsel;
        logic               smem;
        logic               is_jump_abs;
        logic               is_jump_reg;
        logic               is_branch;
        logic [`XLEN-1:0]   imm_ext;
    } decode_ctrl_t;

    // write-back info seen from execute or memory
    typedef struct packed {
        logic               wreg;
        logic [`REG_AW-1:0] wa;
        logic [`XLEN-1:0]   wd;
        logic               mreg;
    } bypass_t;

    typedef struct packed {
        logic               rreg;
        logic [`REG_AW-1:0] ra;
    } rf_port_t;

    typedef struct packed {
        logic             taken;
        logic [`XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic               valid;
        alu_type_e          alutype;
        alu_op_e            aluop;
        logic [`REG_AW-1:0] wa;
        logic               wreg;
        logic               mreg;
        logic [`XLEN-1:0]   src1;
        logic [`XLEN-1:0]   src2;
        logic [`XLEN-1:0]   din;
        logic [`XLEN-1:0]   retaddr;
    } id_ex_t;

endpackage

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_id_stage \
    -f flist.f -o sim_id_stage

./obj_dir/sim_id_stage > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

/* tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one row per cycle; rr is {port 0 enable, port 1 enable}
// flags are {shift amount into src1, immediate into src2, store data into din}
typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [4:0]  exe_sel;
    logic [4:0]  mem_sel;
    logic        stall;
    logic        taken;
    logic [31:0] target;
    alu_type_e   alutype;
    alu_op_e     aluop;
    logic [4:0]  wa;
    logic        wreg;
    logic        mreg;
    logic [1:0]  rr;
    logic [2:0]  flags;
    logic [31:0] imm;
} vec_t;

localparam int NUM_ROWS = 37;

// bypass contents picked by exe_sel and mem_sel, as {wreg, wa, wd, mreg}
bypass_t byp_tab [18] = '{
    '{1'b0, 5'd0,  'h0000_0000, 1'b0},
    '{1'b1, 5'd1,  'haaaa_0001, 1'b0},
    '{1'b1, 5'd1,  'hbbbb_0001, 1'b0},
    '{1'b1, 5'd2,  'hcccc_0002, 1'b0},
    '{1'b1, 5'd12, 'h5555_aaaa, 1'b1},
    '{1'b1, 5'd12, 'h5555_aaaa, 1'b0},
    '{1'b1, 5'd0,  'h1111_2222, 1'b0},
    '{1'b1, 5'd1,  'h0000_0077, 1'b0},
    '{1'b1, 5'd2,  'h0000_0077, 1'b0},
    '{1'b1, 5'd2,  'h0000_0078, 1'b0},
    '{1'b1, 5'd1,  'h0000_0005, 1'b0},
    '{1'b1, 5'd1,  'h0000_0000, 1'b0},
    '{1'b1, 5'd1,  'h8000_0000, 1'b0},
    '{1'b1, 5'd1,  'hffff_ffff, 1'b0},
    '{1'b1, 5'd1,  'h0000_0001, 1'b0},
    '{1'b1, 5'd4,  'h0040_1230, 1'b0},
    '{1'b1, 5'd5,  'h0040_2000, 1'b0},
    '{1'b0, 5'd1,  'hdead_beef, 1'b0}
};

vec_t vectors [NUM_ROWS] = '{
    // idle fetch right after reset
    '{1'b0, 'h0000_0000, 'h0000_0000, 5'd0, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_NOP, ALU_NOP, 5'd0, 1'b0, 1'b0, 2'b00, 3'b000, 'h0},
    '{1'b1, 'h0000_0100, 'h2465_fffc, 5'd0, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_ARITH, ALU_ADDIU, 5'd5, 1'b1, 1'b0, 2'b10, 3'b010, 'hffff_fffc},
    '{1'b1, 'h0000_0104, 'h3446_8001, 5'd0, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_LOGIC, ALU_ORI, 5'd6, 1'b1, 1'b0, 2'b10, 3'b010, 'h0000_8001},
    // lui with an r0 writer upstream, both ports off
    '{1'b1, 'h0000_0108, 'h3c07_1234, 5'd6, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_LOGIC, ALU_LUI, 5'd7, 1'b1, 1'b0, 2'b00, 3'b010, 'h1234_0000},
    '{1'b1, 'h0000_010c, 'h0022_4020, 5'd1, 5'd2, 1'b0, 1'b0, 'h0,
      ALUT_ARITH, ALU_ADD, 5'd8, 1'b1, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_0110, 'h0022_4822, 5'd17, 5'd3, 1'b0, 1'b0, 'h0,
      ALUT_ARITH, ALU_SUB, 5'd9, 1'b1, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_0114, 'h0003_5100, 5'd0, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_SHIFT, ALU_SLL, 5'd10, 1'b1, 1'b0, 2'b01, 3'b100, 'h0},
    '{1'b1, 'h0000_0118, 'h00a4_5807, 5'd0, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_SHIFT, ALU_SRAV, 5'd11, 1'b1, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_011c, 'h8c2c_0010, 5'd0, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_MEM, ALU_LW, 5'd12, 1'b1, 1'b1, 2'b10, 3'b010, 'h0000_0010},
    // consumer of r12 while the load sits in execute, then in memory
    '{1'b1, 'h0000_0120, 'h0182_6820, 5'd4, 5'd0, 1'b1, 1'b0, 'h0,
      ALUT_ARITH, ALU_ADD, 5'd13, 1'b1, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_0120, 'h0182_6820, 5'd0, 5'd4, 1'b1, 1'b0, 'h0,
      ALUT_ARITH, ALU_ADD, 5'd13, 1'b1, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_0120, 'h0182_6820, 5'd0, 5'd5, 1'b0, 1'b0, 'h0,
      ALUT_ARITH, ALU_ADD, 5'd13, 1'b1, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_0124, 'h1182_0008, 5'd4, 5'd0, 1'b1, 1'b0, 'h0,
      ALUT_JUMP, ALU_BEQ, 5'd0, 1'b0, 1'b0, 2'b11, 3'b000, 'h0},
    // same branch held by fetch, load data now forwarded
    '{1'b1, 'h0000_0124, 'h1182_0008, 5'd5, 5'd3, 1'b0, 1'b0, 'h0,
      ALUT_JUMP, ALU_BEQ, 5'd0, 1'b0, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_0128, 'hac62_fff8, 5'd0, 5'd3, 1'b0, 1'b0, 'h0,
      ALUT_MEM, ALU_SW, 5'd31, 1'b0, 1'b0, 2'b11, 3'b011, 'hffff_fff8},
    '{1'b1, 'h0000_1000, 'h1022_0010, 5'd7, 5'd8, 1'b0, 1'b1, 'h0000_1044,
      ALUT_JUMP, ALU_BEQ, 5'd0, 1'b0, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_1000, 'h1022_0010, 5'd7, 5'd9, 1'b0, 1'b0, 'h0,
      ALUT_JUMP, ALU_BEQ, 5'd0, 1'b0, 1'b0, 2'b11, 3'b000, 'h0},
    // backward branch
    '{1'b1, 'h0000_2000, 'h1422_fffe, 5'd7, 5'd9, 1'b0, 1'b1, 'h0000_1ffc,
      ALUT_JUMP, ALU_BNE, 5'd31, 1'b0, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_2000, 'h1422_fffe, 5'd7, 5'd8, 1'b0, 1'b0, 'h0,
      ALUT_JUMP, ALU_BNE, 5'd31, 1'b0, 1'b0, 2'b11, 3'b000, 'h0},
    '{1'b1, 'h0000_3000, 'h1c20_0004, 5'd10, 5'd0, 1'b0, 1'b1, 'h0000_3014,
      ALUT_JUMP, ALU_BGTZ, 5'd0, 1'b0, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_3000, 'h1c20_0004, 5'd11, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_JUMP, ALU_BGTZ, 5'd0, 1'b0, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_3000, 'h1820_0004, 5'd12, 5'd0, 1'b0, 1'b1, 'h0000_3014,
      ALUT_JUMP, ALU_BLEZ, 5'd0, 1'b0, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_3000, 'h1820_0004, 5'd14, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_JUMP, ALU_BLEZ, 5'd0, 1'b0, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_4000, 'h0420_0004, 5'd13, 5'd0, 1'b0, 1'b1, 'h0000_4014,
      ALUT_JUMP, ALU_BLTZ, 5'd0, 1'b0, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_4000, 'h0420_0004, 5'd11, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_JUMP, ALU_BLTZ, 5'd0, 1'b0, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_4000, 'h0421_0004, 5'd11, 5'd0, 1'b0, 1'b1, 'h0000_4014,
      ALUT_JUMP, ALU_BGEZ, 5'd0, 1'b0, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_4000, 'h0421_0004, 5'd12, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_JUMP, ALU_BGEZ, 5'd0, 1'b0, 1'b0, 2'b10, 3'b000, 'h0},
    // linking branches write r31 whether taken or not
    '{1'b1, 'h0000_5000, 'h0430_0004, 5'd13, 5'd0, 1'b0, 1'b1, 'h0000_5014,
      ALUT_JUMP, ALU_BLTZAL, 5'd31, 1'b1, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_5000, 'h0430_0004, 5'd14, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_JUMP, ALU_BLTZAL, 5'd31, 1'b1, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_5000, 'h0431_0004, 5'd14, 5'd0, 1'b0, 1'b1, 'h0000_5014,
      ALUT_JUMP, ALU_BGEZAL, 5'd31, 1'b1, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_5000, 'h0431_0004, 5'd13, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_JUMP, ALU_BGEZAL, 5'd31, 1'b1, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'ha000_0000, 'h0800_0010, 5'd0, 5'd0, 1'b0, 1'b1, 'ha000_0040,
      ALUT_JUMP, ALU_J, 5'd0, 1'b0, 1'b0, 2'b00, 3'b000, 'h0},
    '{1'b1, 'hb000_1000, 'h0c00_0020, 5'd0, 5'd0, 1'b0, 1'b1, 'hb000_0080,
      ALUT_JUMP, ALU_JAL, 5'd31, 1'b1, 1'b0, 2'b00, 3'b000, 'h0},
    '{1'b1, 'h0000_6000, 'h0080_0008, 5'd15, 5'd0, 1'b0, 1'b1, 'h0040_1230,
      ALUT_JUMP, ALU_JR, 5'd0, 1'b0, 1'b0, 2'b10, 3'b000, 'h0},
    '{1'b1, 'h0000_6004, 'h00a0_f809, 5'd16, 5'd0, 1'b0, 1'b1, 'h0040_2000,
      ALUT_JUMP, ALU_JALR, 5'd31, 1'b1, 1'b0, 2'b10, 3'b000, 'h0},
    // opcode 0x3f is not decoded
    '{1'b1, 'h0000_7000, 'hfc00_0000, 5'd0, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_NOP, ALU_NOP, 5'd0, 1'b0, 1'b0, 2'b00, 3'b000, 'h0},
    '{1'b0, 'h0000_7004, 'h0182_6820, 5'd4, 5'd0, 1'b0, 1'b0, 'h0,
      ALUT_NOP, ALU_NOP, 5'd0, 1'b0, 1'b0, 2'b00, 3'b000, 'h0}
};

`endif

/* tb_id_stage.sv */
`include "id_consts.svh"

module tb_id_stage import pipe_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;

    logic             cpu_clk_50M;
    logic             arst_n;
    if_id_t           if_id;
    logic [`XLEN-1:0] rd_data [2];
    bypass_t          exe_byp;
    bypass_t          mem_byp;
    rf_port_t         rf_port [2];
    redirect_t        redirect;
    logic             stall;
    id_ex_t           id_ex;
    logic [31:0]      lfsr_q;
    int               id_ex_errors;
    int               redirect_errors;
    int               port_errors;
    int               stall_errors;

    `include "tb_vectors.svh"

    id_stage_top u_id_stage_top (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n),
        .if_id_i     (if_id),
        .rd_data_i   (rd_data),
        .exe_byp_i   (exe_byp),
        .mem_byp_i   (mem_byp),
        .rf_port_o   (rf_port),
        .redirect_o  (redirect),
        .stall_o     (stall),
        .id_ex_o     (id_ex)
    );

    initial cpu_clk_50M = 1'b0;
    always #(CLK_PERIOD / 2) cpu_clk_50M = ~cpu_clk_50M;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], next_rand_bit()};
        end
        return w;
    endfunction

    // execute first, then memory, then the register file
    function automatic logic [31:0] expected_operand(
        input logic        en,
        input logic [4:0]  ra,
        input bypass_t     exe,
        input bypass_t     mem,
        input logic [31:0] rf
    );
        if (!en)
            return 32'd0;
        if (exe.wreg && exe.wa == ra)
            return exe.wd;
        if (mem.wreg && mem.wa == ra)
            return mem.wd;
        return rf;
    endfunction

    function automatic id_ex_t expected_id_ex(vec_t v, logic [31:0] op0, logic [31:0] op1);
        id_ex_t e;
        e = '0;
        if (v.valid && !v.stall) begin
            e.valid   = 1'b1;
            e.alutype = v.alutype;
            e.aluop   = v.aluop;
            e.wa      = v.wa;
            e.wreg    = v.wreg;
            e.mreg    = v.mreg;
            e.src1    = v.flags[2] ? {27'd0, v.inst[10:6]} : op0;
            e.src2    = v.flags[1] ? v.imm : op1;
            e.din     = v.flags[0] ? op1 : 32'd0;
            e.retaddr = v.pc + 32'd8;
        end
        return e;
    endfunction

    task automatic drive_row(vec_t v);
        if_id.valid = v.valid;
        if_id.pc    = v.pc;
        if_id.inst  = v.inst;
        exe_byp     = byp_tab[v.exe_sel];
        mem_byp     = byp_tab[v.mem_sel];
        rd_data[0]  = rand_word();
        rd_data[1]  = rand_word();
    endtask

    task automatic check_id_ex(int row, id_ex_t got, id_ex_t exp);
        if (got !== exp) begin
            id_ex_errors++;
            $display("ERROR at %0t: row %0d id_ex_o %h (%s), expected %h (%s)",
                     $time, row, got, got.aluop.name(), exp, exp.aluop.name());
        end
    endtask

    task automatic check_redirect(int row, redirect_t got, redirect_t exp);
        if (got !== exp) begin
            redirect_errors++;
            $display("ERROR at %0t: row %0d redirect_o taken %b target %h, expected %b %h",
                     $time, row, got.taken, got.target, exp.taken, exp.target);
        end
    endtask

    task automatic check_rf_port(int row, int k, rf_port_t got, rf_port_t exp);
        if (got !== exp) begin
            port_errors++;
            $display("ERROR at %0t: row %0d rf_port_o[%0d] rreg %b ra %0d, expected %b %0d",
                     $time, row, k, got.rreg, got.ra, exp.rreg, exp.ra);
        end
    endtask

    task automatic check_stall(int row, logic got, logic exp);
        if (got !== exp) begin
            stall_errors++;
            $display("ERROR at %0t: row %0d stall_o %b, expected %b", $time, row, got, exp);
        end
    endtask

    initial begin
        vec_t      v;
        logic [31:0] op0;
        logic [31:0] op1;
        id_ex_t    exp_id_ex;
        redirect_t exp_redirect;
        rf_port_t  exp_port0;
        rf_port_t  exp_port1;
        int        total;

        lfsr_q          = 32'h6c0b_af01;
        id_ex_errors    = 0;
        redirect_errors = 0;
        port_errors     = 0;
        stall_errors    = 0;
        arst_n          = 1'b0;
        if_id           = '0;
        rd_data[0]      = '0;
        rd_data[1]      = '0;
        exe_byp         = '0;
        mem_byp         = '0;

        repeat (5) @(posedge cpu_clk_50M);
        #10;
        // -1 marks the check taken inside reset
        check_id_ex(-1, id_ex, '0);
        arst_n = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            v = vectors[i];
            drive_row(v);
            op0 = expected_operand(v.rr[1], v.inst[25:21], exe_byp, mem_byp, rd_data[0]);
            op1 = expected_operand(v.rr[0], v.inst[20:16], exe_byp, mem_byp, rd_data[1]);
            exp_id_ex           = expected_id_ex(v, op0, op1);
            exp_redirect.taken  = v.taken;
            exp_redirect.target = v.target;
            exp_port0.rreg      = v.rr[1];
            exp_port0.ra        = v.inst[25:21];
            exp_port1.rreg      = v.rr[0];
            exp_port1.ra        = v.inst[20:16];

            // combinational outputs settle well before the next edge
            #80;
            check_stall(i, stall, v.stall);
            check_redirect(i, redirect, exp_redirect);
            check_rf_port(i, 0, rf_port[0], exp_port0);
            check_rf_port(i, 1, rf_port[1], exp_port1);

            @(posedge cpu_clk_50M);
            #1;
            check_id_ex(i, id_ex, exp_id_ex);
            #9;
        end

        total = id_ex_errors + redirect_errors + port_errors + stall_errors;
        $display("errors: id_ex %0d, redirect %0d, rf_port %0d, stall %0d",
                 id_ex_errors, redirect_errors, port_errors, stall_errors);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((NUM_ROWS + 20) * CLK_PERIOD);
        $display("watchdog expired: the table did not finish within %0d cycles",
                 NUM_ROWS + 20);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
